// ==== files.f ====
hdl/uart_pkg.sv
hdl/tcb_lite_if.sv
hdl/uart_fifo.sv
hdl/uart_ser.sv
hdl/uart_des.sv
hdl/tcb_dev_uart.sv
hdl/tcb_lite_dev_uart.sv
hdl/uart_periph_top.sv
sim/uart_periph_props.sv
sim/uart_periph_tb.sv

// ==== hdl/tcb_dev_uart.sv ====
/*
 * UART core, independent of the bus
 * Configuration registers, TX and RX FIFOs, serializer, deserializer, IRQs
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_dev_uart (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         sys_wen,
    input  logic                         sys_ren,
    input  logic [3:0]                   sys_adr,
    input  logic [uart_pkg::BUS_DAT-1:0] sys_wdt,
    output logic [uart_pkg::BUS_DAT-1:0] sys_rdt,
    output logic                         tx_full,
    output logic                         rx_empty,
    input  logic                         uart_rxd,
    output logic                         uart_txd,
    output logic                         irq_tx,
    output logic                         irq_rx
);
    import uart_pkg::*;

    // Configuration registers
    logic [UART_BDR-1:0] cfg_tx_bdr;
    logic [FIFO_CNT-1:0] cfg_tx_irq;
    logic [UART_BDR-1:0] cfg_rx_bdr;
    logic [UART_BDR-1:0] cfg_rx_smp;
    logic [FIFO_CNT-1:0] cfg_rx_irq;

    // TX path
    logic                tx_push;
    logic                tx_pop;
    logic                tx_empty;
    logic [UART_DAT-1:0] tx_rdat;
    logic [FIFO_CNT-1:0] tx_cnt;

    // RX path
    logic                rx_push;
    logic                rx_pop;
    logic [UART_DAT-1:0] rx_dat;
    logic [UART_DAT-1:0] rx_rdat;
    logic [FIFO_CNT-1:0] rx_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Register write decode
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cfg_tx_bdr <= '0;
            cfg_tx_irq <= '0;
            cfg_rx_bdr <= '0;
            cfg_rx_smp <= '0;
            cfg_rx_irq <= '0;
        end
        else if (sys_wen)
        begin
            // Values are truncated to register widths
            case (sys_adr)
                REG_TX_BDR: cfg_tx_bdr <= sys_wdt[UART_BDR-1:0];
                REG_TX_IRQ: cfg_tx_irq <= sys_wdt[FIFO_CNT-1:0];
                REG_RX_BDR: cfg_rx_bdr <= sys_wdt[UART_BDR-1:0];
                REG_RX_SMP: cfg_rx_smp <= sys_wdt[UART_BDR-1:0];
                REG_RX_IRQ: cfg_rx_irq <= sys_wdt[FIFO_CNT-1:0];
                default:    ;
            endcase
        end
    end

    // FIFO strobes from data register access
    assign tx_push = sys_wen & (sys_adr == REG_TX_DAT);
    assign rx_pop  = sys_ren & (sys_adr == REG_RX_DAT);

    ////////////////////////////////////////////////////////////////////////////
    // Read multiplexer
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (sys_adr)
            REG_TX_CNT: sys_rdt = BUS_DAT'(tx_cnt);
            REG_TX_BDR: sys_rdt = BUS_DAT'(cfg_tx_bdr);
            REG_TX_IRQ: sys_rdt = BUS_DAT'(cfg_tx_irq);
            // Empty RX FIFO reads as zero
            REG_RX_DAT: sys_rdt = rx_empty ? '0 : BUS_DAT'(rx_rdat);
            REG_RX_CNT: sys_rdt = BUS_DAT'(rx_cnt);
            REG_RX_BDR: sys_rdt = BUS_DAT'(cfg_rx_bdr);
            REG_RX_SMP: sys_rdt = BUS_DAT'(cfg_rx_smp);
            REG_RX_IRQ: sys_rdt = BUS_DAT'(cfg_rx_irq);
            default:    sys_rdt = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    uart_fifo u_tx_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (tx_push),
        .wdat  (sys_wdt[UART_DAT-1:0]),
        .pop   (tx_pop),
        .rdat  (tx_rdat),
        .cnt   (tx_cnt),
        .full  (tx_full),
        .empty (tx_empty)
    );

    uart_ser u_ser (
        .clk   (clk),
        .rst_n (rst_n),
        .bdr   (cfg_tx_bdr),
        .dat   (tx_rdat),
        .empty (tx_empty),
        .pop   (tx_pop),
        .txd   (uart_txd)
    );

    uart_des u_des (
        .clk   (clk),
        .rst_n (rst_n),
        .bdr   (cfg_rx_bdr),
        .smp   (cfg_rx_smp),
        .rxd   (uart_rxd),
        .push  (rx_push),
        .dat   (rx_dat)
    );

    // Overflow handled inside the FIFO
    uart_fifo u_rx_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (rx_push),
        .wdat  (rx_dat),
        .pop   (rx_pop),
        .rdat  (rx_rdat),
        .cnt   (rx_cnt),
        .full  (),
        .empty (rx_empty)
    );

    // Level interrupts against programmed thresholds
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            irq_tx <= 1'b0;
            irq_rx <= 1'b0;
        end
        else
        begin
            irq_tx <= (tx_cnt < cfg_tx_irq);
            irq_rx <= (rx_cnt > cfg_rx_irq);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tcb_lite_dev_uart.sv ====
/*
 * TCB-lite adapter for the UART core
 * Transfer strobes, back-pressure on a full TX FIFO, error on empty RX read
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_lite_dev_uart (
    tcb_lite_if.sub sub,
    input  logic    uart_rxd,
    output logic    uart_txd,
    output logic    irq_tx,
    output logic    irq_rx
);
    import uart_pkg::*;

    // Transfer in this cycle
    logic       trn;
    // Register index from the byte address
    logic [3:0] sys_adr;
    logic       tx_full;
    logic       rx_empty;

    assign trn     = sub.vld & sub.rdy;
    assign sys_adr = sub.adr[BUS_ADR-1:2];

    // Stall only a data write into a full TX FIFO
    assign sub.rdy = ~(sub.vld & sub.wen & (sys_adr == REG_TX_DAT) & tx_full);

    // Reading an empty RX FIFO
    assign sub.err = trn & ~sub.wen & (sys_adr == REG_RX_DAT) & rx_empty;

    tcb_dev_uart u_uart (
        .clk      (sub.clk),
        .rst_n    (sub.rst_n),
        .sys_wen  (trn & sub.wen),
        .sys_ren  (trn & ~sub.wen),
        .sys_adr  (sys_adr),
        .sys_wdt  (sub.wdt),
        .sys_rdt  (sub.rdt),
        .tx_full  (tx_full),
        .rx_empty (rx_empty),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .irq_tx   (irq_tx),
        .irq_rx   (irq_rx)
    );

endmodule

`default_nettype wire

// ==== hdl/tcb_lite_if.sv ====
/*
 * TCB-lite bus interface
 * Single-cycle request and response with a vld/rdy handshake
 */

`timescale 1ns/1ps
`default_nettype none

interface tcb_lite_if (
    input logic clk,
    input logic rst_n
);
    import uart_pkg::*;

    // Request, driven by the manager
    logic               vld;
    logic               wen;
    logic [BUS_ADR-1:0] adr;
    logic [BUS_DAT-1:0] wdt;

    // Handshake and response, driven by the subordinate
    logic               rdy;
    logic [BUS_DAT-1:0] rdt;
    logic               err;

    // Manager side
    modport man (
        input  clk, rst_n,
        output vld, wen, adr, wdt,
        input  rdy, rdt, err
    );

    // Subordinate side
    modport sub (
        input  clk, rst_n,
        input  vld, wen, adr, wdt,
        output rdy, rdt, err
    );

endinterface

`default_nettype wire

// ==== hdl/uart_des.sv ====
/*
 * UART receive deserializer
 * Start edge detect, programmable first sample, data shift and stop check
 */

`timescale 1ns/1ps
`default_nettype none

module uart_des (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [uart_pkg::UART_BDR-1:0] bdr,
    input  logic [uart_pkg::UART_BDR-1:0] smp,
    input  logic                          rxd,
    output logic                          push,
    output logic [uart_pkg::UART_DAT-1:0] dat
);
    import uart_pkg::*;

    // Two stage synchronizer plus one delay for the edge
    logic                rxd_s;
    logic                rxd_q;
    logic                rxd_d;
    logic                fall;
    // Frame in progress
    logic                busy;
    // Down counter to the next sample
    logic [UART_BDR-1:0] scnt;
    // Bit index, 0 is start and 9 is stop
    logic [3:0]          bit_cnt;
    logic                sample;

    assign fall   = rxd_d & ~rxd_q;
    assign sample = busy & (scnt == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Line input
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            // Idle line is high
            rxd_s <= 1'b1;
            rxd_q <= 1'b1;
            rxd_d <= 1'b1;
        end
        else
        begin
            rxd_s <= rxd;
            rxd_q <= rxd_s;
            rxd_d <= rxd_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            scnt    <= '0;
            bit_cnt <= '0;
            push    <= 1'b0;
        end
        else
        begin
            push <= 1'b0;
            if (!busy)
            begin
                // First sample smp+1 cycles after the edge
                if (fall)
                begin
                    busy    <= 1'b1;
                    scnt    <= smp;
                    bit_cnt <= '0;
                end
            end
            else if (sample)
            begin
                scnt    <= bdr;
                bit_cnt <= bit_cnt + 4'd1;
                // False start, drop the frame
                if (bit_cnt == 4'd0 && rxd_q)
                    busy <= 1'b0;
                // Stop sample, keep only a high stop bit
                if (bit_cnt == 4'd9)
                begin
                    busy <= 1'b0;
                    push <= rxd_q;
                end
            end
            else
                scnt <= scnt - 1'b1;
        end
    end

    // Data shifter, LSB arrives first
    always_ff @(posedge clk)
    begin
        if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9)
            dat <= {rxd_q, dat[UART_DAT-1:1]};
    end

endmodule

`default_nettype wire

// ==== hdl/uart_fifo.sv ====
/*
 * Synchronous register-array FIFO with fill count
 * Head is visible combinationally, overflow and underflow are ignored
 */

`timescale 1ns/1ps
`default_nettype none

module uart_fifo (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push,
    input  logic [uart_pkg::UART_DAT-1:0] wdat,
    input  logic                          pop,
    output logic [uart_pkg::UART_DAT-1:0] rdat,
    output logic [uart_pkg::FIFO_CNT-1:0] cnt,
    output logic                          full,
    output logic                          empty
);
    import uart_pkg::*;

    // Storage
    logic [UART_DAT-1:0] mem [FIFO_SIZ];
    // Pointers wrap naturally, depth is a power of two
    logic [FIFO_ADR-1:0] wptr;
    logic [FIFO_ADR-1:0] rptr;
    // Qualified transfers
    logic                do_push;
    logic                do_pop;

    // Status from the fill count
    assign full    = (cnt == FIFO_CNT'(FIFO_SIZ));
    assign empty   = (cnt == '0);

    // Drop push when full, drop pop when empty
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // Pointers and count
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wptr <= '0;
            rptr <= '0;
            cnt  <= '0;
        end
        else
        begin
            if (do_push)
                wptr <= wptr + 1'b1;
            if (do_pop)
                rptr <= rptr + 1'b1;
            // Push and pop together keep the count
            case ({do_push, do_pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    // Data array write
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wptr] <= wdat;
    end

    // Head of queue
    assign rdat = mem[rptr];

endmodule

`default_nettype wire

// ==== hdl/uart_periph_top.sv ====
/*
 * UART peripheral top level with plain bus ports
 */

`timescale 1ns/1ps
`default_nettype none

module uart_periph_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         bus_vld,
    input  logic                         bus_wen,
    input  logic [uart_pkg::BUS_ADR-1:0] bus_adr,
    input  logic [uart_pkg::BUS_DAT-1:0] bus_wdt,
    output logic                         bus_rdy,
    output logic                         bus_err,
    output logic [uart_pkg::BUS_DAT-1:0] bus_rdt,
    input  logic                         uart_rxd,
    output logic                         uart_txd,
    output logic                         irq_tx,
    output logic                         irq_rx
);

    tcb_lite_if bus (
        .clk   (clk),
        .rst_n (rst_n)
    );

    // Request side
    assign bus.vld = bus_vld;
    assign bus.wen = bus_wen;
    assign bus.adr = bus_adr;
    assign bus.wdt = bus_wdt;

    // Response side
    assign bus_rdy = bus.rdy;
    assign bus_err = bus.err;
    assign bus_rdt = bus.rdt;

    tcb_lite_dev_uart u_dev (
        .sub      (bus),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .irq_tx   (irq_tx),
        .irq_rx   (irq_rx)
    );

endmodule

`default_nettype wire

// ==== hdl/uart_pkg.sv ====
/*
 * UART peripheral shared definitions
 * Bus and character widths, FIFO sizes and the register index map
 */

`default_nettype none

package uart_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus
    ////////////////////////////////////////////////////////////////////////////

    // Data word width
    localparam int unsigned BUS_DAT = 32;
    // Byte address width, register index sits in bits 5..2
    localparam int unsigned BUS_ADR = 6;

    ////////////////////////////////////////////////////////////////////////////
    // UART and FIFO sizes
    ////////////////////////////////////////////////////////////////////////////

    // Baud and sample counter width
    localparam int unsigned UART_BDR = 8;
    // Character width
    localparam int unsigned UART_DAT = 8;

    // FIFO depth
    localparam int unsigned FIFO_SIZ = 8;
    // Pointer and fill count widths
    localparam int unsigned FIFO_ADR = $clog2(FIFO_SIZ);
    localparam int unsigned FIFO_CNT = $clog2(FIFO_SIZ + 1);

    ////////////////////////////////////////////////////////////////////////////
    // Register index map
    ////////////////////////////////////////////////////////////////////////////

    // Transmit side
    localparam logic [3:0] REG_TX_DAT = 4'd0;
    localparam logic [3:0] REG_TX_CNT = 4'd1;
    localparam logic [3:0] REG_TX_BDR = 4'd2;
    localparam logic [3:0] REG_TX_IRQ = 4'd3;
    // Receive side
    localparam logic [3:0] REG_RX_DAT = 4'd8;
    localparam logic [3:0] REG_RX_CNT = 4'd9;
    localparam logic [3:0] REG_RX_BDR = 4'd10;
    localparam logic [3:0] REG_RX_SMP = 4'd11;
    localparam logic [3:0] REG_RX_IRQ = 4'd12;

endpackage

`default_nettype wire

// ==== hdl/uart_ser.sv ====
/*
 * UART transmit serializer
 * Pops a character and shifts out start, 8 data bits LSB first and stop
 */

`timescale 1ns/1ps
`default_nettype none

module uart_ser (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [uart_pkg::UART_BDR-1:0] bdr,
    input  logic [uart_pkg::UART_DAT-1:0] dat,
    input  logic                          empty,
    output logic                          pop,
    output logic                          txd
);
    import uart_pkg::*;

    // Frame in progress
    logic                busy;
    // Cycles within the current bit
    logic [UART_BDR-1:0] bcnt;
    // Bit index, 0 is start and 9 is stop
    logic [3:0]          bit_cnt;
    // Frame shifter, bit 0 is on the line
    logic [9:0]          sreg;
    logic                bit_end;
    logic                frame_end;

    // Bit lasts bdr+1 cycles
    assign bit_end   = busy & (bcnt == bdr);
    assign frame_end = bit_end & (bit_cnt == 4'd9);

    // Take the next character when idle or as the stop bit ends
    assign pop = ~empty & (~busy | frame_end);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            bcnt    <= '0;
            bit_cnt <= '0;
            sreg    <= '1;
        end
        else if (pop)
        begin
            // Stop, data, start
            busy    <= 1'b1;
            bcnt    <= '0;
            bit_cnt <= '0;
            sreg    <= {1'b1, dat, 1'b0};
        end
        else if (frame_end)
        begin
            // Shifter is all ones here, line stays idle
            busy    <= 1'b0;
            bcnt    <= '0;
            bit_cnt <= '0;
        end
        else if (bit_end)
        begin
            bcnt    <= '0;
            bit_cnt <= bit_cnt + 4'd1;
            sreg    <= {1'b1, sreg[9:1]};
        end
        else if (busy)
            bcnt <= bcnt + 1'b1;
    end

    // Line output straight from a flop
    assign txd = sreg[0];

endmodule

`default_nettype wire

// ==== sim/uart_periph_props.sv ====
/*
 * UART core properties
 * Line idle after reset, interrupt levels and TX FIFO bound
 */

`timescale 1ns/1ps
`default_nettype none

module uart_periph_props (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          uart_txd,
    input logic                          irq_tx,
    input logic                          irq_rx,
    input logic [uart_pkg::FIFO_CNT-1:0] tx_cnt,
    input logic [uart_pkg::FIFO_CNT-1:0] rx_cnt,
    input logic [uart_pkg::FIFO_CNT-1:0] cfg_tx_irq,
    input logic [uart_pkg::FIFO_CNT-1:0] cfg_rx_irq
);
    import uart_pkg::*;

    // Number of property failures so far
    int fail_cnt = 0;

    // Line idles high once reset has been seen
    txd_idle_after_reset: assert property (@(posedge clk) !rst_n |=> uart_txd)
    else
    begin
        fail_cnt++;
        $error("uart_txd low in the cycle after reset");
    end

    // Registered IRQs reflect the levels of the previous cycle
    irq_rx_level: assert property (@(posedge clk) disable iff (!rst_n)
        irq_rx |-> $past(rx_cnt > cfg_rx_irq))
    else
    begin
        fail_cnt++;
        $error("irq_rx high while RX count is not above RX_IRQ");
    end

    irq_tx_level: assert property (@(posedge clk) disable iff (!rst_n)
        irq_tx |-> $past(tx_cnt < cfg_tx_irq))
    else
    begin
        fail_cnt++;
        $error("irq_tx high while TX count is not below TX_IRQ");
    end

    // Fill count bounded by the depth
    tx_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        tx_cnt <= FIFO_SIZ)
    else
    begin
        fail_cnt++;
        $error("TX FIFO count above its depth");
    end

endmodule

bind tcb_dev_uart uart_periph_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .uart_txd   (uart_txd),
    .irq_tx     (irq_tx),
    .irq_rx     (irq_rx),
    .tx_cnt     (tx_cnt),
    .rx_cnt     (rx_cnt),
    .cfg_tx_irq (cfg_tx_irq),
    .cfg_rx_irq (cfg_rx_irq)
);

`default_nettype wire

// ==== sim/uart_periph_tb.sv ====
/*
 * Directed testbench for the UART peripheral
 * Registers, transmit, receive, loopback with IRQs and bus back-pressure
 */

`timescale 1ns/1ps
`default_nettype none

module uart_periph_tb;
    import uart_pkg::*;

    // Bit periods of the tests in clock cycles
    localparam int BIT_CYC      = 8;
    localparam int LONG_BIT_CYC = 32;
    localparam int FRAME_CYC    = 10 * BIT_CYC;
    // Twice the time of all frames (8 short, 1 long) plus bus traffic
    localparam int CYCLE_LIMIT  = 2 * (8 * FRAME_CYC + 10 * LONG_BIT_CYC + 400);
    // RX count polls of two cycles each before giving up
    localparam int POLL_LIMIT   = 200;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               bus_vld;
    logic               bus_wen;
    logic [BUS_ADR-1:0] bus_adr;
    logic [BUS_DAT-1:0] bus_wdt;
    logic               bus_rdy;
    logic               bus_err;
    logic [BUS_DAT-1:0] bus_rdt;
    logic               uart_rxd;
    logic               uart_txd;
    logic               irq_tx;
    logic               irq_rx;

    // Line driver and loopback select
    logic               line_rxd;
    logic               loopback;

    int                 errors = 0;
    int                 cycle_cnt;
    int                 stall_cycles;
    logic [31:0]        lcg_state = 32'd73453;

    assign uart_rxd = loopback ? uart_txd : line_rxd;

    always #5 clk = ~clk;

    uart_periph_top u_uart_periph_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_vld  (bus_vld),
        .bus_wen  (bus_wen),
        .bus_adr  (bus_adr),
        .bus_wdt  (bus_wdt),
        .bus_rdy  (bus_rdy),
        .bus_err  (bus_err),
        .bus_rdt  (bus_rdt),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .irq_tx   (irq_tx),
        .irq_rx   (irq_rx)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Linear congruential generator
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAILED %s expected 0x%h got 0x%h", name, exp, got);
        end
    endtask

    // Write that counts the cycles spent with rdy low
    task automatic bus_write(input logic [3:0] idx, input logic [31:0] dat,
                             output int waits);
        waits = 0;
        @(posedge clk);
        bus_vld <= 1'b1;
        bus_wen <= 1'b1;
        bus_adr <= {idx, 2'b00};
        bus_wdt <= dat;
        @(negedge clk);
        while (!bus_rdy)
        begin
            waits++;
            @(negedge clk);
        end
        // Transfer happens on this edge
        @(posedge clk);
        bus_vld <= 1'b0;
        bus_wen <= 1'b0;
    endtask

    // Response sampled mid-cycle of the transfer
    task automatic bus_read(input logic [3:0] idx, output logic [31:0] dat,
                            output logic err);
        @(posedge clk);
        bus_vld <= 1'b1;
        bus_wen <= 1'b0;
        bus_adr <= {idx, 2'b00};
        bus_wdt <= '0;
        @(negedge clk);
        while (!bus_rdy)
            @(negedge clk);
        dat = bus_rdt;
        err = bus_err;
        @(posedge clk);
        bus_vld <= 1'b0;
    endtask

    task automatic read_expect(input logic [3:0] idx, input logic [31:0] exp_dat,
                               input logic exp_err);
        logic [31:0] dat;
        logic        err;
        bus_read(idx, dat, err);
        check_equal($sformatf("bus_rdt[reg %0d]", idx), dat, exp_dat);
        check_equal($sformatf("bus_err[reg %0d]", idx), err, exp_err);
    endtask

    // Poll RX_CNT until it reaches the target
    task automatic wait_rx_count(input int target);
        logic [31:0] cnt;
        logic        err;
        int          polls;
        polls = 0;
        bus_read(REG_RX_CNT, cnt, err);
        while (cnt < target && polls < POLL_LIMIT)
        begin
            polls++;
            bus_read(REG_RX_CNT, cnt, err);
        end
        assert (cnt >= target)
        else
        begin
            errors++;
            $display("RX count did not reach %0d in time", target);
        end
    endtask

    // Start bit, 8 data bits LSB first and the given stop bit
    task automatic send_frame(input logic [7:0] dat, input int period,
                              input logic stop);
        logic [9:0] frame;
        frame = {stop, dat, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            line_rxd <= frame[i];
            repeat (period - 1) @(posedge clk);
        end
        @(posedge clk);
        line_rxd <= 1'b1;
    endtask

    // Sample uart_txd near mid-bit after the start edge
    task automatic recv_frame(input int period, output logic [7:0] dat,
                              output logic start_bit, output logic stop_bit);
        @(negedge clk);
        while (uart_txd !== 1'b0)
            @(negedge clk);
        repeat (period / 2 - 1) @(negedge clk);
        start_bit = uart_txd;
        for (int i = 0; i < 8; i++)
        begin
            repeat (period) @(negedge clk);
            dat[i] = uart_txd;
        end
        repeat (period) @(negedge clk);
        stop_bit = uart_txd;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_registers();
        logic [3:0]  cfg_idx [5];
        int          cfg_wid [5];
        logic [31:0] val;
        cfg_idx = '{REG_TX_BDR, REG_TX_IRQ, REG_RX_BDR, REG_RX_SMP, REG_RX_IRQ};
        cfg_wid = '{UART_BDR, FIFO_CNT, UART_BDR, UART_BDR, FIFO_CNT};
        @(negedge clk);
        check_equal("irq_tx", irq_tx, 1'b0);
        check_equal("irq_rx", irq_rx, 1'b0);
        check_equal("uart_txd", uart_txd, 1'b1);
        check_equal("bus_rdy", bus_rdy, 1'b1);
        // All registers read zero and an empty RX_DAT flags an error
        for (int i = 0; i < 16; i++)
            read_expect(i[3:0], '0, (i == REG_RX_DAT));
        // Readback truncated to register width
        for (int i = 0; i < 5; i++)
        begin
            val = next_random();
            bus_write(cfg_idx[i], val, stall_cycles);
            read_expect(cfg_idx[i], val & ((32'd1 << cfg_wid[i]) - 1), 1'b0);
        end
        // Unused indices
        for (int i = 0; i < 16; i++)
        begin
            if ((i >= 4 && i <= 7) || i >= 13)
            begin
                bus_write(i[3:0], 32'hFFFF_FFFF, stall_cycles);
                read_expect(i[3:0], '0, 1'b0);
            end
        end
    endtask

    task automatic test_transmit();
        logic [7:0] dat;
        logic       start_bit;
        logic       stop_bit;
        bus_write(REG_TX_BDR, BIT_CYC - 1, stall_cycles);
        bus_write(REG_TX_DAT, 32'h0000_00B4, stall_cycles);
        recv_frame(BIT_CYC, dat, start_bit, stop_bit);
        check_equal("uart_txd start bit", start_bit, 1'b0);
        check_equal("uart_txd data", dat, 8'hB4);
        check_equal("uart_txd stop bit", stop_bit, 1'b1);
    endtask

    task automatic test_receive();
        bus_write(REG_RX_BDR, BIT_CYC - 1, stall_cycles);
        bus_write(REG_RX_SMP, 3, stall_cycles);
        send_frame(8'h3C, BIT_CYC, 1'b1);
        wait_rx_count(1);
        read_expect(REG_RX_CNT, 1, 1'b0);
        read_expect(REG_RX_DAT, 32'h3C, 1'b0);
        // Empty FIFO gives an error and zero data
        read_expect(REG_RX_DAT, '0, 1'b1);
        // Frame with a low stop bit is dropped
        send_frame(8'h55, BIT_CYC, 1'b0);
        repeat (2 * BIT_CYC) @(posedge clk);
        read_expect(REG_RX_CNT, 0, 1'b0);
    endtask

    task automatic test_loopback();
        logic [7:0] sent [5];
        @(posedge clk);
        loopback <= 1'b1;
        bus_write(REG_TX_BDR, BIT_CYC - 1, stall_cycles);
        bus_write(REG_RX_BDR, BIT_CYC - 1, stall_cycles);
        bus_write(REG_RX_SMP, 3, stall_cycles);
        bus_write(REG_RX_IRQ, 2, stall_cycles);
        bus_write(REG_TX_IRQ, 1, stall_cycles);
        // IRQ registers lag the threshold by a cycle
        @(posedge clk);
        @(negedge clk);
        check_equal("irq_tx", irq_tx, 1'b1);
        check_equal("irq_rx", irq_rx, 1'b0);
        for (int i = 0; i < 5; i++)
        begin
            sent[i] = 8'(next_random() >> 16);
            bus_write(REG_TX_DAT, {24'h0, sent[i]}, stall_cycles);
        end
        @(negedge clk);
        check_equal("irq_tx", irq_tx, 1'b0);
        wait_rx_count(3);
        @(negedge clk);
        check_equal("irq_rx", irq_rx, 1'b1);
        wait_rx_count(5);
        for (int i = 0; i < 5; i++)
            read_expect(REG_RX_DAT, {24'h0, sent[i]}, 1'b0);
        read_expect(REG_RX_CNT, 0, 1'b0);
        @(posedge clk);
        loopback <= 1'b0;
    endtask

    task automatic test_backpressure();
        int waits;
        bus_write(REG_TX_BDR, LONG_BIT_CYC - 1, stall_cycles);
        // Serializer takes the first byte and the rest fill the FIFO
        for (int i = 0; i <= FIFO_SIZ; i++)
        begin
            bus_write(REG_TX_DAT, 32'h40 + i, waits);
            check_equal("bus_rdy low cycles", waits, 0);
        end
        read_expect(REG_TX_CNT, FIFO_SIZ, 1'b0);
        bus_write(REG_TX_DAT, 32'h4F, waits);
        assert (waits >= 1)
        else
        begin
            errors++;
            $display("TX_DAT write into a full FIFO was accepted without a stall");
        end
        read_expect(REG_TX_CNT, FIFO_SIZ, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        rst_n    = 1'b0;
        bus_vld  = 1'b0;
        bus_wen  = 1'b0;
        bus_adr  = '0;
        bus_wdt  = '0;
        line_rxd = 1'b1;
        loopback = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_registers();
        test_transmit();
        test_receive();
        test_loopback();
        test_backpressure();
        errors += u_uart_periph_top.u_dev.u_uart.u_props.fail_cnt;
        $display("Error count: %0d", errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        errors++;
        $display("Timeout after %0d cycles, run stopped", cycle_cnt);
        $display("Error count: %0d", errors);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
